//--- sys_cont_pkg.sv
`default_nettype none

package sys_cont_pkg;

  //////////////////////////////////////////////////
  // interrupt lines and handler table
  //////////////////////////////////////////////////

  localparam int num_int   = 4;
  localparam int int_idx_w = 2;

  // entry 0 sits in the low word
  localparam logic [num_int-1:0][31:0] idt_addr = {
    32'h0000_f000,
    32'h0000_c000,
    32'h0000_8000,
    32'h0000_4000
  };

  //////////////////////////////////////////////////
  // pipeline flush vector
  //////////////////////////////////////////////////

  localparam int num_flush           = 7;
  localparam int flush_fetch_bit     = 0;
  localparam int flush_decode_0_bit  = 1;
  localparam int flush_decode_1_bit  = 2;
  localparam int flush_register_bit  = 3;
  localparam int flush_address_bit   = 4;
  localparam int flush_execute_bit   = 5;
  localparam int flush_writeback_bit = 6;

  // iretd pops eip, cs, eflags
  localparam int num_pops = 3;

  typedef enum logic [2:0] {
    st_idle,
    st_flush,
    st_wait_dec,
    st_read,
    st_data
  } int_state_e;

  typedef struct packed {
    logic [15:0] unused;
    logic [15:0] cs;
  } pop_sel_s;

  // one stack word, full value or selector view
  typedef union packed {
    logic [31:0] word;
    pop_sel_s    sel;
  } pop_word_u;

endpackage

`default_nettype wire

//--- pipe_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pipe_ctrl_if (
  input logic clk
);
  import sys_cont_pkg::*;

  logic [num_flush-1:0] flush;
  logic                 fetch_load;
  logic [31:0]          fetch_addr;
  logic                 load_eip;
  logic [31:0]          eip;
  logic                 load_cs;
  logic [15:0]          cs;
  logic                 load_eflags;
  logic [31:0]          eflags;

  // one control source
  modport src (
    output flush, fetch_load, fetch_addr, load_eip, eip,
    output load_cs, cs, load_eflags, eflags
  );

  // merge side, clock only for checking
  modport dst (
    input clk,
    input flush, fetch_load, fetch_addr, load_eip, eip,
    input load_cs, cs, load_eflags, eflags
  );

endinterface

`default_nettype wire

//--- int_pending.sv
`timescale 1ns/10ps
`default_nettype none

module int_pending (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic [sys_cont_pkg::num_int-1:0]    int_vec,
  input  logic                                int_clear,
  output logic                                int_any,
  output logic [sys_cont_pkg::int_idx_w-1:0]  int_idx
);
  import sys_cont_pkg::*;

  logic [num_int-1:0]   pend_q;
  logic [num_int-1:0]   pend_d;
  logic [num_int-1:0]   clr_mask;
  logic [int_idx_w-1:0] idx_q;

  // lowest set bit wins
  function automatic logic [int_idx_w-1:0] lowest_idx(input logic [num_int-1:0] v);
    logic [int_idx_w-1:0] idx;
    idx = '0;
    for (int i = num_int - 1; i >= 0; i--) begin
      if (v[i]) begin
        idx = int_idx_w'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    clr_mask = '0;
    if (int_clear) begin
      clr_mask[idx_q] = 1'b1;
    end
    // new request beats the clear
    pend_d = (pend_q & ~clr_mask) | int_vec;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pend_q <= '0;
      idx_q  <= '0;
    end else begin
      pend_q <= pend_d;
      // selection held until the serviced line is retired
      if (!int_any || int_clear) begin
        idx_q <= lowest_idx(pend_d);
      end
    end
  end

  assign int_any = |pend_q;
  assign int_idx = idx_q;

  a_clear_needs_pending: assert property (
    @(posedge clk) disable iff (!arst_n) int_clear |-> int_any
  );

endmodule

`default_nettype wire

//--- int_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module int_fsm (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                int_any,
  input  logic [sys_cont_pkg::int_idx_w-1:0]  int_idx,
  input  logic                                iretd_halt,
  input  logic                                decode_end_int,
  input  logic                                mem_ready,
  input  logic                                mem_dp_valid,
  input  logic [31:0]                         mem_dp_read_data,
  output logic                                mem_valid,
  output logic [31:0]                         mem_address,
  output logic                                mem_dp_ready,
  output logic                                decode_start_int,
  output logic                                int_clear,
  output logic                                int_busy,
  pipe_ctrl_if.src                            ctrl
);
  import sys_cont_pkg::*;

  int_state_e           state_q;
  int_state_e           state_d;
  logic [int_idx_w-1:0] idx_q;
  logic                 take_int;
  logic                 redirect;

  // iretd in progress keeps us in idle
  assign take_int = (state_q == st_idle) && int_any && !iretd_halt;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (take_int) begin
          state_d = st_flush;
        end
      end
      st_flush: begin
        state_d = st_wait_dec;
      end
      st_wait_dec: begin
        if (decode_end_int) begin
          state_d = st_read;
        end
      end
      st_read: begin
        if (mem_ready) begin
          state_d = st_data;
        end
      end
      st_data: begin
        if (mem_dp_valid) begin
          state_d = st_idle;
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // table index frozen for the whole service
  always_ff @(posedge clk) begin
    if (take_int) begin
      idx_q <= int_idx;
    end
  end

  //////////////////////////////////////////////////
  // memory, decode and pipeline control
  //////////////////////////////////////////////////

  assign mem_valid        = (state_q == st_read);
  assign mem_address      = mem_valid ? idt_addr[idx_q] : 32'h0;
  assign mem_dp_ready     = (state_q == st_data);
  assign decode_start_int = (state_q == st_flush);

  // handler word arrives, redirect in the same cycle
  assign redirect  = mem_dp_ready && mem_dp_valid;
  assign int_clear = redirect;

  // also busy in the cycle we commit, so iretd cannot start alongside
  assign int_busy = (state_q != st_idle) || take_int;

  assign ctrl.flush       = (state_q == st_flush) ? '1 : '0;
  assign ctrl.fetch_load  = redirect;
  assign ctrl.fetch_addr  = redirect ? mem_dp_read_data : 32'h0;
  assign ctrl.load_cs     = redirect;
  assign ctrl.cs          = 16'h0;
  assign ctrl.load_eip    = 1'b0;
  assign ctrl.eip         = 32'h0;
  assign ctrl.load_eflags = 1'b0;
  assign ctrl.eflags      = 32'h0;

  a_addr_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    mem_valid && !mem_ready |=> $stable(mem_address)
  );

  a_start_pulse: assert property (
    @(posedge clk) disable iff (!arst_n)
    decode_start_int |=> !decode_start_int
  );

endmodule

`default_nettype wire

//--- pop_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pop_counter (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  logic       pop,
  output logic       active,
  output logic [1:0] pop_idx,
  output logic       last
);
  import sys_cont_pkg::*;

  logic [1:0] cnt_q;

  // zero is idle, 1..num_pops name the next word
  assign active  = (cnt_q != 2'd0);
  assign pop_idx = cnt_q;
  assign last    = active && pop && (cnt_q == 2'(num_pops));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= 2'd0;
    end else if (!active && start) begin
      cnt_q <= 2'd1;
    end else if (active && pop) begin
      cnt_q <= last ? 2'd0 : cnt_q + 2'd1;
    end
  end

  a_pop_when_active: assert property (
    @(posedge clk) disable iff (!arst_n) pop |-> active
  );

endmodule

`default_nettype wire

//--- iretd_seq.sv
`timescale 1ns/10ps
`default_nettype none

module iretd_seq (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        iretd,
  input  logic        int_busy,
  input  logic        iretd_pop_valid,
  input  logic [31:0] iretd_pop_data,
  output logic        iretd_halt,
  pipe_ctrl_if.src    ctrl
);
  import sys_cont_pkg::*;

  pop_word_u   pop_word;
  logic        active;
  logic [1:0]  pop_idx;
  logic        last;
  logic        pop_eip;
  logic        pop_cs;
  logic [31:0] eip_q;

  pop_counter u_pop_cnt (
    .clk     (clk),
    .arst_n  (arst_n),
    .start   (iretd && !int_busy),
    .pop     (iretd_pop_valid),
    .active  (active),
    .pop_idx (pop_idx),
    .last    (last)
  );

  assign pop_word = iretd_pop_data;

  // word order on the stack: eip, cs, eflags
  assign pop_eip = active && iretd_pop_valid && (pop_idx == 2'd1);
  assign pop_cs  = active && iretd_pop_valid && (pop_idx == 2'd2);

  always_ff @(posedge clk) begin
    if (pop_eip) begin
      eip_q <= pop_word.word;
    end
  end

  assign iretd_halt = active;

  always_comb begin
    ctrl.flush = '0;
    // fetch stays quiet while the frame is popped
    ctrl.flush[flush_fetch_bit] = iretd_halt;
  end

  assign ctrl.load_eip    = pop_eip;
  assign ctrl.eip         = pop_eip ? pop_word.word : 32'h0;
  assign ctrl.load_cs     = pop_cs;
  assign ctrl.cs          = pop_cs ? pop_word.sel.cs : 16'h0;
  assign ctrl.load_eflags = last;
  assign ctrl.eflags      = last ? pop_word.word : 32'h0;
  assign ctrl.fetch_load  = last;
  assign ctrl.fetch_addr  = last ? eip_q : 32'h0;

endmodule

`default_nettype wire

//--- ctrl_merge.sv
`timescale 1ns/10ps
`default_nettype none

module ctrl_merge (
  pipe_ctrl_if.dst    int_ctrl,
  pipe_ctrl_if.dst    ret_ctrl,
  output logic        flush_fetch,
  output logic        flush_decode_0,
  output logic        flush_decode_1,
  output logic        flush_register,
  output logic        flush_address,
  output logic        flush_execute,
  output logic        flush_writeback,
  output logic        fetch_load,
  output logic [31:0] fetch_load_address,
  output logic        reg_load_eip,
  output logic [31:0] reg_eip,
  output logic        reg_load_cs,
  output logic [15:0] reg_cs,
  output logic        reg_load_eflags,
  output logic [31:0] reg_eflags
);
  import sys_cont_pkg::*;

  logic [num_flush-1:0] flush_all;
  logic [3:0]           int_loads;
  logic [3:0]           ret_loads;

  assign flush_all = int_ctrl.flush | ret_ctrl.flush;

  assign flush_fetch     = flush_all[flush_fetch_bit];
  assign flush_decode_0  = flush_all[flush_decode_0_bit];
  assign flush_decode_1  = flush_all[flush_decode_1_bit];
  assign flush_register  = flush_all[flush_register_bit];
  assign flush_address   = flush_all[flush_address_bit];
  assign flush_execute   = flush_all[flush_execute_bit];
  assign flush_writeback = flush_all[flush_writeback_bit];

  // data follows whichever source strobes
  assign fetch_load         = int_ctrl.fetch_load | ret_ctrl.fetch_load;
  assign fetch_load_address = int_ctrl.fetch_load ? int_ctrl.fetch_addr : ret_ctrl.fetch_addr;
  assign reg_load_eip       = int_ctrl.load_eip | ret_ctrl.load_eip;
  assign reg_eip            = int_ctrl.load_eip ? int_ctrl.eip : ret_ctrl.eip;
  assign reg_load_cs        = int_ctrl.load_cs | ret_ctrl.load_cs;
  assign reg_cs             = int_ctrl.load_cs ? int_ctrl.cs : ret_ctrl.cs;
  assign reg_load_eflags    = int_ctrl.load_eflags | ret_ctrl.load_eflags;
  assign reg_eflags         = int_ctrl.load_eflags ? int_ctrl.eflags : ret_ctrl.eflags;

  assign int_loads = {int_ctrl.fetch_load, int_ctrl.load_eip,
                      int_ctrl.load_cs, int_ctrl.load_eflags};
  assign ret_loads = {ret_ctrl.fetch_load, ret_ctrl.load_eip,
                      ret_ctrl.load_cs, ret_ctrl.load_eflags};

  a_no_double_load: assert property (
    @(posedge int_ctrl.clk) (int_loads & ret_loads) == 4'b0
  );

endmodule

`default_nettype wire

//--- sys_cont_top.sv
`timescale 1ns/10ps
`default_nettype none

module sys_cont_top (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [sys_cont_pkg::num_int-1:0]  int_vec,
  output logic                              mem_valid,
  input  logic                              mem_ready,
  output logic [31:0]                       mem_address,
  input  logic                              mem_dp_valid,
  output logic                              mem_dp_ready,
  input  logic [31:0]                       mem_dp_read_data,
  output logic                              flush_fetch,
  output logic                              flush_decode_0,
  output logic                              flush_decode_1,
  output logic                              flush_register,
  output logic                              flush_address,
  output logic                              flush_execute,
  output logic                              flush_writeback,
  output logic                              fetch_load,
  output logic [31:0]                       fetch_load_address,
  output logic                              decode_start_int,
  input  logic                              decode_end_int,
  output logic                              reg_load_cs,
  output logic [15:0]                       reg_cs,
  input  logic                              iretd,
  output logic                              iretd_halt,
  input  logic                              iretd_pop_valid,
  input  logic [31:0]                       iretd_pop_data,
  output logic                              reg_load_eflags,
  output logic [31:0]                       reg_eflags,
  output logic                              reg_load_eip,
  output logic [31:0]                       reg_eip
);
  import sys_cont_pkg::*;

  logic                 int_any;
  logic [int_idx_w-1:0] int_idx;
  logic                 int_clear;
  logic                 int_busy;

  pipe_ctrl_if int_ctrl (.clk(clk));
  pipe_ctrl_if ret_ctrl (.clk(clk));

  //////////////////////////////////////////////////
  // interrupt entry
  //////////////////////////////////////////////////

  int_pending u_int_pending (
    .clk       (clk),
    .arst_n    (arst_n),
    .int_vec   (int_vec),
    .int_clear (int_clear),
    .int_any   (int_any),
    .int_idx   (int_idx)
  );

  int_fsm u_int_fsm (
    .clk              (clk),
    .arst_n           (arst_n),
    .int_any          (int_any),
    .int_idx          (int_idx),
    .iretd_halt       (iretd_halt),
    .decode_end_int   (decode_end_int),
    .mem_ready        (mem_ready),
    .mem_dp_valid     (mem_dp_valid),
    .mem_dp_read_data (mem_dp_read_data),
    .mem_valid        (mem_valid),
    .mem_address      (mem_address),
    .mem_dp_ready     (mem_dp_ready),
    .decode_start_int (decode_start_int),
    .int_clear        (int_clear),
    .int_busy         (int_busy),
    .ctrl             (int_ctrl)
  );

  //////////////////////////////////////////////////
  // interrupt return and merge
  //////////////////////////////////////////////////

  iretd_seq u_iretd_seq (
    .clk             (clk),
    .arst_n          (arst_n),
    .iretd           (iretd),
    .int_busy        (int_busy),
    .iretd_pop_valid (iretd_pop_valid),
    .iretd_pop_data  (iretd_pop_data),
    .iretd_halt      (iretd_halt),
    .ctrl            (ret_ctrl)
  );

  ctrl_merge u_ctrl_merge (
    .int_ctrl           (int_ctrl),
    .ret_ctrl           (ret_ctrl),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute),
    .flush_writeback    (flush_writeback),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags)
  );

endmodule

`default_nettype wire

//--- tb_sys_cont.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sys_cont;
  import sys_cont_pkg::*;

  logic        clk;
  logic        arst_n;
  logic [3:0]  int_vec;
  logic        mem_valid;
  logic        mem_ready;
  logic [31:0] mem_address;
  logic        mem_dp_valid;
  logic        mem_dp_ready;
  logic [31:0] mem_dp_read_data;
  logic        flush_fetch;
  logic        flush_decode_0;
  logic        flush_decode_1;
  logic        flush_register;
  logic        flush_address;
  logic        flush_execute;
  logic        flush_writeback;
  logic        fetch_load;
  logic [31:0] fetch_load_address;
  logic        decode_start_int;
  logic        decode_end_int;
  logic        reg_load_cs;
  logic [15:0] reg_cs;
  logic        iretd;
  logic        iretd_halt;
  logic        iretd_pop_valid;
  logic [31:0] iretd_pop_data;
  logic        reg_load_eflags;
  logic [31:0] reg_eflags;
  logic        reg_load_eip;
  logic [31:0] reg_eip;

  int chk_cnt = 0;
  int err_cnt = 0;
  int to_cnt = 0;
  int max_stall = 0;
  int dec_left = 0;

  // events seen by the models and the monitor
  logic [31:0] fetch_q[$];
  logic        cs_load_q[$];
  logic [15:0] cs_q[$];
  logic [6:0]  flush_q[$];
  logic [31:0] rd_addr_q[$];

  sys_cont_top u_dut (
    .clk                (clk),
    .arst_n             (arst_n),
    .int_vec            (int_vec),
    .mem_valid          (mem_valid),
    .mem_ready          (mem_ready),
    .mem_address        (mem_address),
    .mem_dp_valid       (mem_dp_valid),
    .mem_dp_ready       (mem_dp_ready),
    .mem_dp_read_data   (mem_dp_read_data),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute),
    .flush_writeback    (flush_writeback),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .decode_start_int   (decode_start_int),
    .decode_end_int     (decode_end_int),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .iretd              (iretd),
    .iretd_halt         (iretd_halt),
    .iretd_pop_valid    (iretd_pop_valid),
    .iretd_pop_data     (iretd_pop_data),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    chk_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("at %0t ns: %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    to_cnt++;
    $display("timeout at %0t ns: %s", $time, msg);
  endtask

  task automatic drive_point();
    @(posedge clk);
    #2;
  endtask

  task automatic sample_point();
    @(negedge clk);
    #1;
  endtask

  function automatic logic [31:0] table_addr(input int line);
    case (line)
      0: return 32'h0000_4000;
      1: return 32'h0000_8000;
      2: return 32'h0000_c000;
      default: return 32'h0000_f000;
    endcase
  endfunction

  // distinct word for every address
  function automatic logic [31:0] handler_word(input logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h5a5a_0c3c;
  endfunction

  function automatic int stall_len();
    return $urandom % (max_stall + 1);
  endfunction

  //////////////////////////////////////////////////
  // memory, decoder and monitor models
  //////////////////////////////////////////////////

  always begin : memory_model
    logic        nxt_ready;
    logic        nxt_dp_valid;
    logic [31:0] nxt_data;
    logic        rd_busy;
    logic        dp_pending;
    int          rd_stall;
    int          dp_stall;
    logic [31:0] rd_addr;
    logic [31:0] dp_data;
    @(negedge clk);
    nxt_ready = 1'b0;
    nxt_dp_valid = 1'b0;
    nxt_data = 32'h0;
    if (!arst_n) begin
      rd_busy = 1'b0;
      dp_pending = 1'b0;
    end
    if (mem_valid && !mem_ready) begin
      if (!rd_busy) begin
        rd_busy = 1'b1;
        rd_addr = mem_address;
        rd_stall = stall_len();
        rd_addr_q.push_back(mem_address);
      end else begin
        check_value("mem_address", rd_addr, mem_address);
      end
      if (rd_stall == 0) begin
        nxt_ready = 1'b1;
      end else begin
        rd_stall--;
      end
    end
    if (mem_valid && mem_ready) begin
      rd_busy = 1'b0;
      dp_pending = 1'b1;
      dp_stall = stall_len();
      dp_data = handler_word(mem_address);
    end
    if (mem_dp_ready && !mem_dp_valid && dp_pending) begin
      if (dp_stall == 0) begin
        nxt_dp_valid = 1'b1;
        nxt_data = dp_data;
      end else begin
        dp_stall--;
      end
    end
    if (mem_dp_ready && mem_dp_valid) begin
      dp_pending = 1'b0;
    end
    drive_point();
    mem_ready = nxt_ready;
    mem_dp_valid = nxt_dp_valid;
    mem_dp_read_data = nxt_data;
  end

  // decoder ends its sequence a few cycles after the start pulse
  always begin : decoder_model
    logic nxt_end;
    @(negedge clk);
    nxt_end = 1'b0;
    if (decode_start_int) begin
      dec_left = 3;
    end else if (dec_left > 0) begin
      dec_left--;
      nxt_end = (dec_left == 0);
    end
    drive_point();
    decode_end_int = nxt_end;
  end

  always @(negedge clk) begin : monitor
    if (fetch_load) begin
      fetch_q.push_back(fetch_load_address);
      cs_load_q.push_back(reg_load_cs);
      cs_q.push_back(reg_cs);
    end
    if (decode_start_int) begin
      flush_q.push_back({flush_writeback, flush_execute, flush_address, flush_register,
                         flush_decode_1, flush_decode_0, flush_fetch});
    end
  end

  //////////////////////////////////////////////////
  // stimulus and checking tasks
  //////////////////////////////////////////////////

  task automatic raise_lines(input logic [3:0] lines);
    drive_point();
    int_vec = lines;
    drive_point();
    int_vec = 4'b0;
  endtask

  task automatic wait_for_fetch(input string what);
    int n;
    n = 0;
    sample_point();
    while (fetch_q.size() == 0 && n < 300) begin
      sample_point();
      n++;
    end
    if (fetch_q.size() == 0) begin
      report_timeout({"no fetch redirect for ", what});
    end
  endtask

  task automatic wait_table_read();
    int n;
    n = 0;
    sample_point();
    while (!mem_valid && n < 100) begin
      sample_point();
      n++;
    end
    if (!mem_valid) begin
      report_timeout("interrupt FSM never requested the handler table");
    end
  endtask

  task automatic check_service(input int line);
    logic [31:0] addr;
    addr = table_addr(line);
    wait_for_fetch($sformatf("interrupt line %0d", line));
    if (fetch_q.size() > 0) begin
      check_value("fetch_load_address", handler_word(addr), fetch_q.pop_front());
      check_value("reg_load_cs", 1, cs_load_q.pop_front());
      check_value("reg_cs", 0, cs_q.pop_front());
    end
    if (rd_addr_q.size() > 0) begin
      check_value("mem_address", addr, rd_addr_q.pop_front());
    end else begin
      report_failure($sformatf("no table read seen for line %0d", line));
    end
    if (flush_q.size() > 0) begin
      check_value("flush outputs at decode_start_int", 7'h7f, flush_q.pop_front());
    end else begin
      report_failure($sformatf("no decode start pulse seen for line %0d", line));
    end
  endtask

  task automatic start_iretd();
    int n;
    drive_point();
    iretd = 1'b1;
    drive_point();
    iretd = 1'b0;
    n = 0;
    sample_point();
    while (!iretd_halt && n < 20) begin
      sample_point();
      n++;
    end
    if (!iretd_halt) begin
      report_timeout("iretd_halt did not rise after iretd");
    end
  endtask

  // stack model, one word per valid cycle with growing gaps
  task automatic pop_frame(input logic [31:0] w_eip, input logic [31:0] w_cs,
                           input logic [31:0] w_eflags);
    pop_word_u words [3];
    words[0].word = w_eip;
    words[1].word = w_cs;
    words[2].word = w_eflags;
    for (int i = 0; i < 3; i++) begin
      repeat (i + 1) begin
        drive_point();
        iretd_pop_valid = 1'b0;
        iretd_pop_data = 32'h0;
        sample_point();
        check_value("iretd_halt", 1, iretd_halt);
        check_value("flush_fetch", 1, flush_fetch);
        check_value("decode_start_int", 0, decode_start_int);
        check_value("mem_valid", 0, mem_valid);
      end
      drive_point();
      iretd_pop_valid = 1'b1;
      iretd_pop_data = words[i].word;
      sample_point();
      check_value("iretd_halt", 1, iretd_halt);
      check_value("flush_fetch", 1, flush_fetch);
      if (i == 0) begin
        check_value("reg_load_eip", 1, reg_load_eip);
        check_value("reg_eip", w_eip, reg_eip);
      end else if (i == 1) begin
        check_value("reg_load_cs", 1, reg_load_cs);
        check_value("reg_cs", w_cs[15:0], reg_cs);
      end else begin
        check_value("reg_load_eflags", 1, reg_load_eflags);
        check_value("reg_eflags", w_eflags, reg_eflags);
        check_value("fetch_load", 1, fetch_load);
        check_value("fetch_load_address", w_eip, fetch_load_address);
      end
    end
    drive_point();
    iretd_pop_valid = 1'b0;
    iretd_pop_data = 32'h0;
    sample_point();
    check_value("iretd_halt", 0, iretd_halt);
    if (fetch_q.size() > 0) begin
      check_value("fetch_load_address", w_eip, fetch_q.pop_front());
      check_value("reg_load_cs", 0, cs_load_q.pop_front());
      void'(cs_q.pop_front());
    end else begin
      report_failure("no fetch redirect seen at the end of the interrupt return");
    end
  endtask

  task automatic check_reset_state();
    sample_point();
    check_value("flush outputs", 0, {flush_writeback, flush_execute, flush_address,
                flush_register, flush_decode_1, flush_decode_0, flush_fetch});
    check_value("fetch_load", 0, fetch_load);
    check_value("reg_load_eip", 0, reg_load_eip);
    check_value("reg_load_cs", 0, reg_load_cs);
    check_value("reg_load_eflags", 0, reg_load_eflags);
    check_value("mem_valid", 0, mem_valid);
    check_value("mem_dp_ready", 0, mem_dp_ready);
    check_value("decode_start_int", 0, decode_start_int);
    check_value("iretd_halt", 0, iretd_halt);
  endtask

  task automatic test_each_line();
    for (int line = 0; line < 4; line++) begin
      raise_lines(4'b0001 << line);
      check_service(line);
    end
  endtask

  task automatic test_priority();
    raise_lines(4'b0101);
    check_service(0);
    check_service(2);
  endtask

  task automatic test_busy();
    raise_lines(4'b0010);
    wait_table_read();
    raise_lines(4'b1000);
    check_service(1);
    check_service(3);
  endtask

  task automatic test_backpressure();
    max_stall = 5;
    raise_lines(4'b1111);
    for (int line = 0; line < 4; line++) begin
      check_service(line);
    end
    raise_lines(4'b0100);
    check_service(2);
    max_stall = 0;
  endtask

  task automatic test_iretd();
    start_iretd();
    pop_frame(32'h0012_3450, 32'hdead_0023, 32'h0000_0246);
  endtask

  task automatic test_exclusion();
    start_iretd();
    raise_lines(4'b0100);
    pop_frame(32'h00ab_cd10, 32'h5555_001b, 32'h0000_0202);
    check_service(2);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : main
    arst_n = 1'b0;
    int_vec = 4'b0;
    mem_ready = 1'b0;
    mem_dp_valid = 1'b0;
    mem_dp_read_data = 32'h0;
    decode_end_int = 1'b0;
    iretd = 1'b0;
    iretd_pop_valid = 1'b0;
    iretd_pop_data = 32'h0;
    void'($urandom(32'h2db9ad23));
    repeat (10) @(posedge clk);
    #2;
    arst_n = 1'b1;

    check_reset_state();
    test_each_line();
    test_priority();
    test_busy();
    test_backpressure();
    test_iretd();
    test_exclusion();

    // nothing may follow once all lines are serviced
    repeat (20) sample_point();
    check_value("extra fetch_load events", 0, fetch_q.size());
    check_value("extra table reads", 0, rd_addr_q.size());
    check_value("extra decode start pulses", 0, flush_q.size());

    $display("checks: %0d, value errors: %0d, timeouts: %0d", chk_cnt, err_cnt, to_cnt);
    if (err_cnt == 0 && to_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
sys_cont_pkg.sv
pipe_ctrl_if.sv
int_pending.sv
int_fsm.sv
pop_counter.sv
iretd_seq.sv
ctrl_merge.sv
sys_cont_top.sv
tb_sys_cont.sv

//--- Bender.yml
package:
  name: sys_cont

sources:
  - files:
      - sys_cont_pkg.sv
      - pipe_ctrl_if.sv
      - int_pending.sv
      - int_fsm.sv
      - pop_counter.sv
      - iretd_seq.sv
      - ctrl_merge.sv
      - sys_cont_top.sv
  - target: test
    files:
      - tb_sys_cont.sv
